/* hdl/ob_pkg.sv */
// ***********************************************************
// Shared widths, table geometry and control state encoding
// for the order book depth counter
// ***********************************************************

`default_nettype none

package ob_pkg;

  // Order price
  typedef logic [15:0] price_t;

  // Quantity of a single resting order
  typedef logic [9:0] quantity_t;

  // Accumulated quantity, wide enough for TABLE_N maximal orders
  typedef logic [15:0] accum_quantity_t;

  // Number of resting entries in the table
  localparam int TABLE_N = 17;

  // Inputs to the carry-save tree
  localparam int CSA_DEGREE_N = 8;

  // Table lanes per round, two tree inputs go to the running sum/carry
  localparam int LANE_N = CSA_DEGREE_N - 2;

  // Rounds needed to cover the whole table
  localparam int ROUND_N = (TABLE_N + LANE_N - 1) / LANE_N;

  // Control FSM states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    // One round of lanes latched per cycle
    ST_ACCUM = 2'd1,
    // Fold in the last latched round
    ST_DRAIN = 2'd2
  } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/ob_qualify.sv */
// ***********************************************************
// Per-entry price compare against the command price
// Non-crossing or invalid entries contribute zero quantity
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module ob_qualify #(
  parameter bit is_ask = 1'b1
) (
  input  wire ob_pkg::price_t                           ctx_price,
  input  wire logic [ob_pkg::TABLE_N-1:0]               tbl_valid,
  input  wire ob_pkg::price_t [ob_pkg::TABLE_N-1:0]     tbl_price,
  input  wire ob_pkg::quantity_t [ob_pkg::TABLE_N-1:0]  tbl_quantity,
  output ob_pkg::quantity_t [ob_pkg::TABLE_N-1:0]       qual_quantity
);

  // Per-entry crossing result
  logic [ob_pkg::TABLE_N-1:0] crosses;

  // Side-dependent compare
  always_comb begin
    for (int i = 0; i < ob_pkg::TABLE_N; i++) begin
      if (is_ask) begin
        // Ask side, a buyer at this price or above can take the entry
        crosses[i] = (ctx_price >= tbl_price[i]);
      end else begin
        // Bid side, a seller at this price or below can hit the entry
        crosses[i] = (ctx_price <= tbl_price[i]);
      end
    end
  end

  // Pass quantity only for valid crossing entries
  always_comb begin
    for (int i = 0; i < ob_pkg::TABLE_N; i++) begin
      if (tbl_valid[i] && crosses[i]) begin
        qual_quantity[i] = tbl_quantity[i];
      end else begin
        qual_quantity[i] = '0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ob_csa_tree.sv */
// ***********************************************************
// 3:2 carry-save reduction of LANE_N lanes plus the running
// sum/carry pair down to a single sum/carry pair
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module ob_csa_tree (
  input  wire ob_pkg::quantity_t [ob_pkg::LANE_N-1:0] lane_quantity,
  input  wire ob_pkg::accum_quantity_t                acc_s_in,
  input  wire ob_pkg::accum_quantity_t                acc_c_in,
  output ob_pkg::accum_quantity_t                     sum,
  output ob_pkg::accum_quantity_t                     carry
);

  // Tree inputs, lanes widened to the accumulator width
  ob_pkg::accum_quantity_t [ob_pkg::CSA_DEGREE_N-1:0] x;

  // Intermediate sums and carries per layer
  ob_pkg::accum_quantity_t [4:0] s;
  ob_pkg::accum_quantity_t [4:0] c;

  // Bitwise full-adder sum
  function automatic ob_pkg::accum_quantity_t csa_sum(
    ob_pkg::accum_quantity_t a, ob_pkg::accum_quantity_t b, ob_pkg::accum_quantity_t d);
    return a ^ b ^ d;
  endfunction

  // Bitwise majority, moved up one weight
  function automatic ob_pkg::accum_quantity_t csa_carry(
    ob_pkg::accum_quantity_t a, ob_pkg::accum_quantity_t b, ob_pkg::accum_quantity_t d);
    return ((a & b) | (a & d) | (b & d)) << 1;
  endfunction

  always_comb begin
    for (int i = 0; i < ob_pkg::LANE_N; i++) begin
      x[i] = ob_pkg::accum_quantity_t'(lane_quantity[i]);
    end
    // Running partial result takes the last two inputs
    x[ob_pkg::CSA_DEGREE_N-2] = acc_s_in;
    x[ob_pkg::CSA_DEGREE_N-1] = acc_c_in;

    // Layer 1, 8 terms to 6
    s[0] = csa_sum(x[0], x[1], x[2]);
    c[0] = csa_carry(x[0], x[1], x[2]);
    s[1] = csa_sum(x[3], x[4], x[5]);
    c[1] = csa_carry(x[3], x[4], x[5]);

    // Layer 2, 6 terms to 4
    s[2] = csa_sum(s[0], c[0], s[1]);
    c[2] = csa_carry(s[0], c[0], s[1]);
    s[3] = csa_sum(c[1], x[6], x[7]);
    c[3] = csa_carry(c[1], x[6], x[7]);

    // Layer 3, 4 terms to 3
    s[4] = csa_sum(s[2], c[2], s[3]);
    c[4] = csa_carry(s[2], c[2], s[3]);

    // Layer 4, 3 terms to the final pair
    sum   = csa_sum(s[4], c[4], c[3]);
    carry = csa_carry(s[4], c[4], c[3]);
  end

endmodule

`default_nettype wire

/* hdl/ob_accumulate.sv */
// ***********************************************************
// Round select, lane mux and lane register
// Carry-save accumulator registers around the CSA tree
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module ob_accumulate (
  input  wire logic                                     clk,
  input  wire logic                                     rst,
  input  wire ob_pkg::quantity_t [ob_pkg::TABLE_N-1:0]  qual_quantity,
  input  wire logic                                     acc_init,
  input  wire logic                                     acc_upt,
  input  wire logic                                     round_start,
  input  wire logic                                     round_step,
  output logic                                          round_last,
  output ob_pkg::accum_quantity_t                       acc_s,
  output ob_pkg::accum_quantity_t                       acc_c
);

  // One-hot round select
  logic [ob_pkg::ROUND_N-1:0] round_sel;

  // Table entries arranged by round and lane
  ob_pkg::quantity_t [ob_pkg::ROUND_N-1:0][ob_pkg::LANE_N-1:0] round_slot;

  // Lane mux output and its register
  ob_pkg::quantity_t [ob_pkg::LANE_N-1:0] lane_d;
  ob_pkg::quantity_t [ob_pkg::LANE_N-1:0] lane_q;

  // Tree outputs
  ob_pkg::accum_quantity_t csa_s;
  ob_pkg::accum_quantity_t csa_c;

  // Highest entry goes first; slots past entry 0 are padding
  for (genvar r = 0; r < ob_pkg::ROUND_N; r++) begin : g_round
    for (genvar l = 0; l < ob_pkg::LANE_N; l++) begin : g_lane
      localparam int IDX = ob_pkg::TABLE_N - 1 - (r * ob_pkg::LANE_N + l);
      if (IDX >= 0) begin : g_entry
        assign round_slot[r][l] = qual_quantity[IDX];
      end else begin : g_pad
        assign round_slot[r][l] = '0;
      end
    end
  end

  // Round select, loaded with the first round then shifted
  always_ff @(posedge clk) begin
    if (rst) begin
      round_sel <= '0;
    end else if (round_start) begin
      round_sel <= ob_pkg::ROUND_N'(1);
    end else if (round_step) begin
      round_sel <= round_sel << 1;
    end
  end

  assign round_last = round_sel[ob_pkg::ROUND_N-1];

  // AND-OR mux over rounds, select is one-hot
  always_comb begin
    for (int l = 0; l < ob_pkg::LANE_N; l++) begin
      lane_d[l] = '0;
      for (int r = 0; r < ob_pkg::ROUND_N; r++) begin
        if (round_sel[r]) begin
          lane_d[l] = lane_d[l] | round_slot[r][l];
        end
      end
    end
  end

  // Lane register, latched once per round
  always_ff @(posedge clk) begin
    if (round_step) begin
      lane_q <= lane_d;
    end
  end

  ob_csa_tree u_csa_tree (
    .lane_quantity (lane_q),
    .acc_s_in      (acc_s),
    .acc_c_in      (acc_c),
    .sum           (csa_s),
    .carry         (csa_c)
  );

  // Running sum/carry, cleared at command start
  always_ff @(posedge clk) begin
    if (acc_init) begin
      acc_s <= '0;
      acc_c <= '0;
    end else if (acc_upt) begin
      acc_s <= csa_s;
      acc_c <= csa_c;
    end
  end

endmodule

`default_nettype wire

/* hdl/ob_count_ctrl.sv */
// ***********************************************************
// Command acceptance, price context capture and the round
// sequencing FSM
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module ob_count_ctrl (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            cmd_valid,
  input  wire ob_pkg::price_t  cmd_price,
  input  wire logic            pending,
  input  wire logic            round_last,
  output logic                 cmd_ready,
  output ob_pkg::price_t       ctx_price,
  output logic                 acc_init,
  output logic                 acc_upt,
  output logic                 round_start,
  output logic                 round_step,
  output logic                 done
);

  ob_pkg::ctrl_state_t state;
  ob_pkg::ctrl_state_t state_nxt;

  // High in the first ST_ACCUM cycle, lane register not yet loaded
  logic accum_first;
  logic accept;

  // Idle, no response waiting and none about to be raised
  assign cmd_ready = (state == ob_pkg::ST_IDLE) && !pending && !done;
  assign accept    = cmd_valid && cmd_ready;

  // Datapath strobes
  assign acc_init    = accept;
  assign round_start = accept;
  assign round_step  = (state == ob_pkg::ST_ACCUM);
  assign acc_upt     = ((state == ob_pkg::ST_ACCUM) && !accum_first) ||
                       (state == ob_pkg::ST_DRAIN);

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      ob_pkg::ST_IDLE: begin
        if (accept) begin
          state_nxt = ob_pkg::ST_ACCUM;
        end
      end
      ob_pkg::ST_ACCUM: begin
        // Last round is being latched this cycle
        if (round_last) begin
          state_nxt = ob_pkg::ST_DRAIN;
        end
      end
      ob_pkg::ST_DRAIN: begin
        state_nxt = ob_pkg::ST_IDLE;
      end
      default: begin
        state_nxt = ob_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ob_pkg::ST_IDLE;
      accum_first <= 1'b0;
      done        <= 1'b0;
    end else begin
      state       <= state_nxt;
      accum_first <= accept;
      // One cycle after the drain, accumulator final
      done        <= (state == ob_pkg::ST_DRAIN);
    end
  end

  // Command price held for the whole scan
  always_ff @(posedge clk) begin
    if (accept) begin
      ctx_price <= cmd_price;
    end
  end

endmodule

`default_nettype wire

/* hdl/ob_count_result.sv */
// ***********************************************************
// Goal register, final carry-propagate add, attained compare
// and response hold
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module ob_count_result (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     cmd_valid,
  input  wire logic                     cmd_ready,
  input  wire ob_pkg::quantity_t        cmd_quantity,
  input  wire logic                     done,
  input  wire ob_pkg::accum_quantity_t  acc_s,
  input  wire ob_pkg::accum_quantity_t  acc_c,
  input  wire logic                     rsp_ready,
  output logic                          pending,
  output logic                          rsp_valid,
  output ob_pkg::accum_quantity_t       rsp_quantity,
  output logic                          rsp_attained
);

  // Goal quantity, widened at capture
  ob_pkg::accum_quantity_t goal;

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      goal <= ob_pkg::accum_quantity_t'(cmd_quantity);
    end
  end

  // Raised on done, held until the consumer takes it
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else if (done) begin
      rsp_valid <= 1'b1;
    end else if (rsp_valid && rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  assign pending = rsp_valid;

  // Single carry-propagate add resolves the carry-save pair
  assign rsp_quantity = acc_s + acc_c;
  assign rsp_attained = (rsp_quantity >= goal);

endmodule

`default_nettype wire

/* hdl/ob_depth_count.sv */
// ***********************************************************
// Order book depth counter top level
// Control, qualify, accumulate and result instances
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module ob_depth_count #(
  parameter bit is_ask = 1'b1
) (
  input  wire logic                                     clk,
  input  wire logic                                     rst,
  input  wire logic                                     cmd_valid,
  output logic                                          cmd_ready,
  input  wire ob_pkg::price_t                           cmd_price,
  input  wire ob_pkg::quantity_t                        cmd_quantity,
  input  wire logic [ob_pkg::TABLE_N-1:0]               tbl_valid,
  input  wire ob_pkg::price_t [ob_pkg::TABLE_N-1:0]     tbl_price,
  input  wire ob_pkg::quantity_t [ob_pkg::TABLE_N-1:0]  tbl_quantity,
  output logic                                          rsp_valid,
  input  wire logic                                     rsp_ready,
  output ob_pkg::accum_quantity_t                       rsp_quantity,
  output logic                                          rsp_attained
);

  // Control to datapath
  ob_pkg::price_t ctx_price;
  logic           acc_init;
  logic           acc_upt;
  logic           round_start;
  logic           round_step;
  logic           done;

  // Datapath back to control
  logic           round_last;
  logic           pending;

  ob_pkg::quantity_t [ob_pkg::TABLE_N-1:0] qual_quantity;
  ob_pkg::accum_quantity_t                 acc_s;
  ob_pkg::accum_quantity_t                 acc_c;

  ob_count_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_price   (cmd_price),
    .pending     (pending),
    .round_last  (round_last),
    .cmd_ready   (cmd_ready),
    .ctx_price   (ctx_price),
    .acc_init    (acc_init),
    .acc_upt     (acc_upt),
    .round_start (round_start),
    .round_step  (round_step),
    .done        (done)
  );

  ob_qualify #(.is_ask(is_ask)) u_qualify (
    .ctx_price     (ctx_price),
    .tbl_valid     (tbl_valid),
    .tbl_price     (tbl_price),
    .tbl_quantity  (tbl_quantity),
    .qual_quantity (qual_quantity)
  );

  ob_accumulate u_accumulate (
    .clk           (clk),
    .rst           (rst),
    .qual_quantity (qual_quantity),
    .acc_init      (acc_init),
    .acc_upt       (acc_upt),
    .round_start   (round_start),
    .round_step    (round_step),
    .round_last    (round_last),
    .acc_s         (acc_s),
    .acc_c         (acc_c)
  );

  ob_count_result u_result (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_quantity (cmd_quantity),
    .done         (done),
    .acc_s        (acc_s),
    .acc_c        (acc_c),
    .rsp_ready    (rsp_ready),
    .pending      (pending),
    .rsp_valid    (rsp_valid),
    .rsp_quantity (rsp_quantity),
    .rsp_attained (rsp_attained)
  );

endmodule

`default_nettype wire

/* dv/tb_ob_depth_count.sv */
// ***********************************************************
// Testbench for the order book depth counter
// Clock, reset, LCG stimulus, reference model, assertions
// and cycle-count timeout
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_ob_depth_count #(
  parameter bit is_ask = 1'b1
);

  localparam int RESET_CYCLES = 8;
  localparam int RAND_N       = 200;
  // All invalid twice, all full, entry 0 only twice
  localparam int CORNER_N     = 5;
  localparam int CYCLE_LIMIT  = (RAND_N + CORNER_N) * 40 + RESET_CYCLES;

  logic clk = 1'b0;
  logic rst;
  logic cmd_valid;
  logic cmd_ready;
  ob_pkg::price_t    cmd_price;
  ob_pkg::quantity_t cmd_quantity;
  logic [ob_pkg::TABLE_N-1:0]              tbl_valid;
  ob_pkg::price_t [ob_pkg::TABLE_N-1:0]    tbl_price;
  ob_pkg::quantity_t [ob_pkg::TABLE_N-1:0] tbl_quantity;
  logic rsp_valid;
  logic rsp_ready;
  ob_pkg::accum_quantity_t rsp_quantity;
  logic rsp_attained;

  // Table being built for the next command
  logic [ob_pkg::TABLE_N-1:0]              nxt_valid;
  ob_pkg::price_t [ob_pkg::TABLE_N-1:0]    nxt_price;
  ob_pkg::quantity_t [ob_pkg::TABLE_N-1:0] nxt_quantity;

  // Expected response of the command in flight
  ob_pkg::accum_quantity_t exp_quantity;
  logic exp_attained;

  // Bookkeeping for the protocol checks
  int   cycle = 0;
  int   accept_cycle;
  logic started;
  logic in_flight;
  logic [31:0] lcg_state = 32'd62857;

  always #5 clk = ~clk;

  ob_depth_count #(.is_ask(is_ask)) dut0 (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_price    (cmd_price),
    .cmd_quantity (cmd_quantity),
    .tbl_valid    (tbl_valid),
    .tbl_price    (tbl_price),
    .tbl_quantity (tbl_quantity),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .rsp_quantity (rsp_quantity),
    .rsp_attained (rsp_attained)
  );

  // LCG step whose upper bits are the useful ones
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Sum of valid entries that cross the limit price on this side
  function automatic ob_pkg::accum_quantity_t depth_model(
    input logic [ob_pkg::TABLE_N-1:0]              valid,
    input ob_pkg::price_t [ob_pkg::TABLE_N-1:0]    price,
    input ob_pkg::quantity_t [ob_pkg::TABLE_N-1:0] qty,
    input ob_pkg::price_t                          limit);
    ob_pkg::accum_quantity_t total = '0;
    logic hit;
    for (int i = 0; i < ob_pkg::TABLE_N; i++) begin
      hit = is_ask ? (limit >= price[i]) : (limit <= price[i]);
      if (valid[i] && hit) begin
        total = total + ob_pkg::accum_quantity_t'(qty[i]);
      end
    end
    return total;
  endfunction

  task automatic fail_check(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "check failed");
  endtask

  // Sampled at each edge with the pre-edge values
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (rst) begin
      started      <= 1'b0;
      in_flight    <= 1'b0;
      accept_cycle <= 0;
    end else if (cmd_valid && cmd_ready) begin
      started      <= 1'b1;
      in_flight    <= 1'b1;
      accept_cycle <= cycle;
    end else if (rsp_valid && rsp_ready) begin
      in_flight <= 1'b0;
    end
  end

  always @(posedge clk) begin
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout, no progress after %0d cycles", cycle);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  // Idle after reset
  assert property (@(posedge clk) disable iff (rst) !started |-> (cmd_ready && !rsp_valid))
    else fail_check("cmd_ready low or rsp_valid high before the first command");
  assert property (@(posedge clk) disable iff (rst) rsp_valid |-> rsp_quantity == exp_quantity)
    else fail_check($sformatf("rsp_quantity %0d expected %0d",
                              $sampled(rsp_quantity), $sampled(exp_quantity)));
  assert property (@(posedge clk) disable iff (rst) rsp_valid |-> rsp_attained == exp_attained)
    else fail_check($sformatf("rsp_attained %0b expected %0b",
                              $sampled(rsp_attained), $sampled(exp_attained)));
  // Raised by edge ROUND_N+2 after acceptance and seen at the following sample
  assert property (@(posedge clk) disable iff (rst)
    $rose(rsp_valid) |-> (cycle - accept_cycle == ob_pkg::ROUND_N + 3))
    else fail_check($sformatf("rsp_valid rose %0d edges after acceptance",
                              $sampled(cycle) - $sampled(accept_cycle) - 1));
  assert property (@(posedge clk) disable iff (rst) in_flight |-> !cmd_ready)
    else fail_check("cmd_ready high while a command is in flight");
  assert property (@(posedge clk) disable iff (rst) rsp_valid |-> !cmd_ready)
    else fail_check("cmd_ready high while a response waits");
  assert property (@(posedge clk) disable iff (rst) $past(rsp_valid && rsp_ready) |-> cmd_ready)
    else fail_check("cmd_ready not back high after the response handshake");
  // Response held under back-pressure
  assert property (@(posedge clk) disable iff (rst) $past(rsp_valid && !rsp_ready) |-> rsp_valid)
    else fail_check("rsp_valid dropped before the handshake");
  assert property (@(posedge clk) disable iff (rst) $past(rsp_valid && !rsp_ready) |->
    (rsp_quantity == $past(rsp_quantity) && rsp_attained == $past(rsp_attained)))
    else fail_check("response changed while rsp_ready was low");

  // One full command with the table from nxt_* and a random response policy
  task automatic run_command(input ob_pkg::price_t price, input ob_pkg::quantity_t goal);
    ob_pkg::accum_quantity_t total;
    logic [31:0] r;
    logic early;
    int hold;
    total = depth_model(nxt_valid, nxt_price, nxt_quantity, price);
    r = lcg_next();
    early = r[31];
    hold = int'(r[30:28]);
    @(posedge clk);
    tbl_valid    <= nxt_valid;
    tbl_price    <= nxt_price;
    tbl_quantity <= nxt_quantity;
    cmd_valid    <= 1'b1;
    cmd_price    <= price;
    cmd_quantity <= goal;
    exp_quantity <= total;
    exp_attained <= (total >= ob_pkg::accum_quantity_t'(goal));
    rsp_ready    <= early;
    do @(posedge clk); while (!cmd_ready);
    cmd_valid <= 1'b0;
    // With rsp_ready already high this edge is the handshake
    do @(posedge clk); while (!rsp_valid);
    if (!early) begin
      repeat (hold) begin
        // Decoy command that must be refused while the response waits
        r = lcg_next();
        cmd_valid    <= r[31];
        cmd_price    <= ob_pkg::price_t'(r[29:14]);
        cmd_quantity <= ob_pkg::quantity_t'(r[27:18]);
        @(posedge clk);
      end
      rsp_ready <= 1'b1;
      cmd_valid <= 1'b0;
      @(posedge clk);
    end
    rsp_ready <= 1'b0;
  endtask

  // Prices in a narrow band so that many compare equal
  task automatic random_command();
    logic [31:0] r;
    ob_pkg::price_t base;
    ob_pkg::quantity_t qmask;
    ob_pkg::quantity_t gmask;
    r = lcg_next();
    base  = ob_pkg::price_t'(r[25:16]) + ob_pkg::price_t'(100);
    qmask = r[31] ? 10'h3ff : 10'h03f;
    gmask = r[30] ? 10'h3ff : 10'h0ff;
    for (int i = 0; i < ob_pkg::TABLE_N; i++) begin
      r = lcg_next();
      nxt_valid[i]    = (r[27:26] != 2'b00);
      nxt_price[i]    = base + ob_pkg::price_t'(r[19:18]);
      nxt_quantity[i] = ob_pkg::quantity_t'(r[31:22]) & qmask;
    end
    r = lcg_next();
    run_command(base + ob_pkg::price_t'(r[18:16]) - ob_pkg::price_t'(1),
                ob_pkg::quantity_t'(r[31:22]) & gmask);
  endtask

  // Corner tables crossing at equal price on either side
  task automatic corner_commands();
    ob_pkg::price_t p;
    p = ob_pkg::price_t'(500);
    for (int i = 0; i < ob_pkg::TABLE_N; i++) begin
      nxt_valid[i]    = 1'b0;
      nxt_price[i]    = p;
      nxt_quantity[i] = 10'h3ff;
    end
    run_command(p, 10'd0);
    run_command(p, 10'd1);
    // Every entry at full quantity without overflow of the sum
    nxt_valid = '1;
    run_command(p, 10'h3ff);
    // Entry 0 sits in the padded last round
    for (int i = 1; i < ob_pkg::TABLE_N; i++) begin
      nxt_price[i] = is_ask ? p + ob_pkg::price_t'(1) : p - ob_pkg::price_t'(1);
    end
    nxt_quantity[0] = 10'd777;
    run_command(p, 10'd777);
    run_command(p, 10'd778);
  endtask

  initial begin
    rst          <= 1'b1;
    cmd_valid    <= 1'b0;
    cmd_price    <= '0;
    cmd_quantity <= '0;
    tbl_valid    <= '0;
    tbl_price    <= '0;
    tbl_quantity <= '0;
    rsp_ready    <= 1'b0;
    exp_quantity <= '0;
    exp_attained <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    // A few idle cycles before the first command
    repeat (3) @(posedge clk);
    corner_commands();
    for (int n = 0; n < RAND_N; n++) begin
      random_command();
    end
    repeat (3) @(posedge clk);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/ob_pkg.sv
hdl/ob_qualify.sv
hdl/ob_csa_tree.sv
hdl/ob_accumulate.sv
hdl/ob_count_ctrl.sv
hdl/ob_count_result.sv
hdl/ob_depth_count.sv
dv/tb_ob_depth_count.sv

/* run.sh */
#!/bin/sh
# Builds and runs the depth counter testbench for the ask side, then the bid side
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_ob_depth_count \
  -Gis_ask=1 -Mdir obj_ask -o sim_ask &&
./obj_ask/sim_ask &&
verilator --binary --timing --assert -f all.f --top-module tb_ob_depth_count \
  -Gis_ask=0 -Mdir obj_bid -o sim_bid &&
./obj_bid/sim_bid &&
echo "ask and bid runs finished" ||
{ echo "simulation stopped with an error"; exit 1; }
